// File: include/alu_defines.svh
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// Width of the integer datapath.
`define ALU_DATA_W 32

// Physical register file size, banked registers included.
`define ALU_PHY_REGS 46

// Physical index of the program counter.
`define ALU_PC_INDEX 15

// Opcode field width.
`define ALU_OP_W 4

`endif

// File: hw/alu_pkg.sv
`include "alu_defines.svh"

package alu_pkg;

        typedef logic [`ALU_DATA_W-1:0]            word_t;
        typedef logic [$clog2(`ALU_PHY_REGS)-1:0]  reg_idx_t;
        typedef logic [3:0]                        flags_t;   // N Z C V, N on top.

        // Standard ARM condition field encoding.
        typedef enum logic [3:0] {
                EQ, NE, CS, CC, MI, PL, VS, VC,
                HI, LS, GE, LT, GT, LE, AL, NV
        } cond_e;

        // Logical group first, so op <= ORR selects it.
        typedef enum logic [`ALU_OP_W-1:0] {
                AND, EOR, BIC, MOV, MVN, ORR,
                ADD, ADC, SUB, RSB, SBC, RSC
        } alu_op_e;

        // Instruction as handed over by the shift stage.
        typedef struct packed {
                word_t    rn;
                word_t    rm;
                logic     shift_carry;
                logic     rrx;
                cond_e    cond;
                alu_op_e  op;
                logic     flag_update;
                reg_idx_t dest;
                logic     exc;
        } exec_req_t;

        // Registered slot towards the memory stage.
        typedef struct packed {
                logic     valid;
                logic     exc;
                word_t    result;
                reg_idx_t dest;
        } exec_rsp_t;

endpackage

// File: hw/cond_check.sv
`timescale 1ns/10ps

module cond_check
        import alu_pkg::*;
(
        input  cond_e  i_cond,
        input  flags_t i_flags,
        output logic   o_pass
);

        logic n, z, c, v;

        assign {n, z, c, v} = i_flags;

        always_comb
        begin
                o_pass = 1'b0;
                case (i_cond)
                        EQ: o_pass = z;
                        NE: o_pass = ~z;
                        CS: o_pass = c;
                        CC: o_pass = ~c;
                        MI: o_pass = n;
                        PL: o_pass = ~n;
                        VS: o_pass = v;
                        VC: o_pass = ~v;
                        HI: o_pass = c & ~z;                  // Unsigned higher.
                        LS: o_pass = ~c | z;
                        GE: o_pass = (n == v);                // Signed compares.
                        LT: o_pass = (n != v);
                        GT: o_pass = ~z & (n == v);
                        LE: o_pass = z | (n != v);
                        AL: o_pass = 1'b1;
                        NV: o_pass = 1'b0;                    // Empty slot.
                        default: o_pass = 1'b0;
                endcase
        end

endmodule

// File: hw/alu_datapath.sv
`timescale 1ns/10ps

`include "alu_defines.svh"

module alu_datapath
        import alu_pkg::*;
(
        input  exec_req_t i_req,
        input  flags_t    i_flags,
        output word_t     o_result,
        output flags_t    o_flags_nxt
);

        logic  n_in, z_in, c_in, v_in;
        word_t op_b;       // Shifted operand after optional RRX.
        logic  op_carry;
        word_t add_a;
        word_t add_b;
        logic  add_cin;
        word_t add_sum;
        logic  add_cout;
        logic  add_ovf;
        logic  is_logic;

        assign {n_in, z_in, c_in, v_in} = i_flags;

        // RRX rotates through the stored carry.
        always_comb
        begin
                if (i_req.rrx)
                begin
                        op_b     = {c_in, i_req.rm[`ALU_DATA_W-1:1]};
                        op_carry = i_req.rm[0];
                end
                else
                begin
                        op_b     = i_req.rm;
                        op_carry = i_req.shift_carry;
                end
        end

        // Every arithmetic op maps onto one adder.
        always_comb
        begin
                add_a   = i_req.rn;
                add_b   = op_b;
                add_cin = 1'b0;
                case (i_req.op)
                        ADC: add_cin = c_in;
                        SUB: {add_b, add_cin} = {~op_b, 1'b1};
                        RSB: {add_a, add_b, add_cin} = {op_b, ~i_req.rn, 1'b1};
                        SBC: {add_b, add_cin} = {~op_b, c_in};
                        RSC: {add_a, add_b, add_cin} = {op_b, ~i_req.rn, c_in};
                        default: ;
                endcase
        end

        assign {add_cout, add_sum} = {1'b0, add_a} + {1'b0, add_b} + {{`ALU_DATA_W{1'b0}}, add_cin};

        // Same sign in, different sign out.
        assign add_ovf = (add_a[`ALU_DATA_W-1] == add_b[`ALU_DATA_W-1]) &&
                         (add_sum[`ALU_DATA_W-1] != add_a[`ALU_DATA_W-1]);

        assign is_logic = (i_req.op <= ORR);

        always_comb
        begin
                case (i_req.op)
                        AND:     o_result = i_req.rn & op_b;
                        EOR:     o_result = i_req.rn ^ op_b;
                        BIC:     o_result = i_req.rn & ~op_b;
                        MOV:     o_result = op_b;
                        MVN:     o_result = ~op_b;
                        ORR:     o_result = i_req.rn | op_b;
                        default: o_result = add_sum;
                endcase
        end

        // All four bits recomputed on a flag update.
        always_comb
        begin
                if (i_req.flag_update)
                begin
                        o_flags_nxt[3] = o_result[`ALU_DATA_W-1];
                        o_flags_nxt[2] = (o_result == '0);
                        o_flags_nxt[1] = is_logic ? op_carry : add_cout;
                        o_flags_nxt[0] = is_logic ? v_in : add_ovf;  // Logical ops keep V.
                end
                else
                begin
                        o_flags_nxt = {n_in, z_in, c_in, v_in};
                end
        end

endmodule

// File: hw/alu_stage_reg.sv
`timescale 1ns/10ps

`include "alu_defines.svh"

module alu_stage_reg
        import alu_pkg::*;
(
        input  logic      i_clk,
        input  logic      i_reset,
        input  logic      i_clear,
        input  logic      i_stall,
        input  exec_req_t i_req,
        input  logic      i_pass,
        input  word_t     i_result,
        input  flags_t    i_flags_nxt,
        output flags_t    o_flags,
        output logic      o_awake,
        output exec_rsp_t o_rsp
);

        typedef enum logic {
                AWAKE,
                ASLEEP
        } sleep_state_e;

        sleep_state_e state_q;
        logic         exec_valid;
        logic         pc_write;
        logic         go_sleep;

        // Exception tag kills the slot regardless of condition.
        assign exec_valid = i_pass & ~i_req.exc;
        assign pc_write   = exec_valid && (i_req.dest == reg_idx_t'(`ALU_PC_INDEX));
        assign go_sleep   = i_req.exc | pc_write;

        assign o_awake = (state_q == AWAKE);

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_rsp   <= '0;
                        o_flags <= '0;
                        state_q <= AWAKE;
                end
                else if (i_clear)
                begin
                        o_rsp   <= '0;      // Flags survive a flush.
                        state_q <= AWAKE;
                end
                else if (i_stall)
                begin
                        // Hold everything.
                        o_rsp   <= o_rsp;
                end
                else if (state_q == ASLEEP)
                begin
                        o_rsp   <= '0;      // Bubbles until write-back clears us.
                end
                else
                begin
                        o_rsp.valid  <= exec_valid;
                        o_rsp.exc    <= i_req.exc;
                        o_rsp.result <= i_result;
                        o_rsp.dest   <= i_req.dest;

                        if (exec_valid)
                        begin
                                o_flags <= i_flags_nxt;
                        end

                        // Branch or exception, wait for the flush.
                        if (go_sleep)
                        begin
                                state_q <= ASLEEP;
                        end
                end
        end

endmodule

// File: hw/alu_stage.sv
`timescale 1ns/10ps

`include "alu_defines.svh"

module alu_stage
        import alu_pkg::*;
(
        input  logic      i_clk,
        input  logic      i_reset,
        input  logic      i_clear,
        input  logic      i_stall,
        input  exec_req_t i_req,
        output exec_rsp_t o_rsp,
        output flags_t    o_flags,
        output logic      o_branch,
        output word_t     o_branch_pc
);

        logic   pass;
        logic   awake;
        word_t  result_nxt;
        flags_t flags_nxt;

        cond_check u_cond (
                .i_cond   (i_req.cond),
                .i_flags  (o_flags),
                .o_pass   (pass)
        );

        alu_datapath u_datapath (
                .i_req       (i_req),
                .i_flags     (o_flags),
                .o_result    (result_nxt),
                .o_flags_nxt (flags_nxt)
        );

        alu_stage_reg u_reg (
                .i_clk       (i_clk),
                .i_reset     (i_reset),
                .i_clear     (i_clear),
                .i_stall     (i_stall),
                .i_req       (i_req),
                .i_pass      (pass),
                .i_result    (result_nxt),
                .i_flags_nxt (flags_nxt),
                .o_flags     (o_flags),
                .o_awake     (awake),
                .o_rsp       (o_rsp)
        );

        // Fetch redirect on a taken write to the PC.
        assign o_branch = awake & ~i_stall & ~i_clear & ~i_req.exc & pass &
                          (i_req.dest == reg_idx_t'(`ALU_PC_INDEX));

        assign o_branch_pc = o_branch ? result_nxt : '0;

endmodule

// File: verif/alu_stage_assert.sv
`timescale 1ns/10ps

module alu_stage_assert
        import alu_pkg::*;
(
        input logic      i_clk,
        input logic      i_reset,
        input logic      i_clear,
        input logic      i_stall,
        input logic      i_awake,
        input exec_rsp_t i_rsp,
        input flags_t    i_flags
);

        int failures;   // Read by the testbench.

        a_clear_kills: assert property (@(posedge i_clk) disable iff (i_reset)
                i_clear |=> !i_rsp.valid)
        else
        begin
                $error("Slot still valid one cycle after a clear.");
                failures++;
        end

        // A stall freezes the slot and the flags.
        a_stall_holds: assert property (@(posedge i_clk) disable iff (i_reset)
                (i_stall && !i_clear) |=> ($stable(i_rsp) && $stable(i_flags)))
        else
        begin
                $error("Output changed during a stall.");
                failures++;
        end

        a_sleep_quiet: assert property (@(posedge i_clk) disable iff (i_reset)
                !i_awake |=> !$rose(i_rsp.valid))
        else
        begin
                $error("Valid slot emitted while asleep.");
                failures++;
        end

endmodule

bind alu_stage_reg alu_stage_assert u_assert (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_clear (i_clear),
        .i_stall (i_stall),
        .i_awake (o_awake),
        .i_rsp   (o_rsp),
        .i_flags (o_flags)
);

// File: verif/alu_stage_checker.sv
`timescale 1ns/10ps

`include "alu_defines.svh"

module alu_stage_checker
        import alu_pkg::*;
(
        input  logic      i_clk,
        input  logic      i_reset,
        input  logic      i_clear,
        input  logic      i_stall,
        input  exec_req_t i_req,
        input  exec_rsp_t i_rsp,
        input  flags_t    i_flags,
        input  logic      i_branch,
        input  word_t     i_branch_pc,
        output int        o_errors
);

        exec_rsp_t exp_rsp;
        flags_t    exp_flags;
        logic      asleep;
        bit        primed;     // Set once the first reset edge is seen.

        // cond[3:1] picks the test and cond[0] inverts it, as in the ARM ARM.
        function automatic logic cond_passes(input logic [3:0] cond, input flags_t f);
                logic base;

                case (cond[3:1])
                        3'd0:    base = f[2];
                        3'd1:    base = f[1];
                        3'd2:    base = f[3];
                        3'd3:    base = f[0];
                        3'd4:    base = f[1] && !f[2];
                        3'd5:    base = (f[3] == f[0]);
                        3'd6:    base = (f[3] == f[0]) && !f[2];
                        default: base = 1'b1;
                endcase
                return (cond == 4'hf) ? 1'b0 : (cond[0] ? !base : base);
        endfunction

        // Exact integer arithmetic, range checks give C and V. Returns {nzcv, result}.
        function automatic logic [`ALU_DATA_W+3:0] expected_exec(input exec_req_t r,
                                                                 input flags_t f);
                word_t  b;
                word_t  x;
                word_t  y;
                word_t  res;
                logic   c;
                logic   v;
                longint ext;
                longint u;
                longint s;

                b = r.rrx ? ((r.rm >> 1) | (word_t'(f[1]) << (`ALU_DATA_W - 1))) : r.rm;
                c = r.rrx ? r.rm[0] : r.shift_carry;
                v = f[0];
                {x, y} = (r.op == RSB || r.op == RSC) ? {b, r.rn} : {r.rn, b};
                ext = (r.op == ADC) ? longint'(f[1]) :
                      (r.op == SBC || r.op == RSC) ? longint'(!f[1]) : 64'sd0;
                if (r.op >= SUB)
                begin
                        u = longint'(x) - longint'(y) - ext;
                        s = longint'(signed'(x)) - longint'(signed'(y)) - ext;
                end
                else
                begin
                        u = longint'(x) + longint'(y) + ext;
                        s = longint'(signed'(x)) + longint'(signed'(y)) + ext;
                end
                case (r.op)
                        AND:     res = r.rn & b;
                        EOR:     res = r.rn ^ b;
                        BIC:     res = r.rn & ~b;
                        MOV:     res = b;
                        MVN:     res = ~b;
                        ORR:     res = r.rn | b;
                        default: res = word_t'(u);
                endcase
                if (r.op >= ADD)
                begin
                        c = (r.op >= SUB) ? (u >= 64'sd0) : (u >= 64'sd4294967296);  // No borrow.
                        v = (s > 64'sd2147483647) || (s < -64'sd2147483648);
                end
                return r.flag_update ? {res[`ALU_DATA_W-1], res == '0, c, v, res} : {f, res};
        endfunction

        always @(posedge i_clk)
        begin : step
                logic [`ALU_DATA_W+3:0] outcome;
                logic                   valid;
                logic                   exp_branch;
                word_t                  exp_pc;

                outcome    = expected_exec(i_req, exp_flags);
                valid      = cond_passes(i_req.cond, exp_flags) && !i_req.exc;
                exp_branch = !asleep && !i_stall && !i_clear && valid &&
                             (i_req.dest == reg_idx_t'(`ALU_PC_INDEX));
                exp_pc     = exp_branch ? outcome[`ALU_DATA_W-1:0] : '0;

                // Registered outputs still show the previous edge here.
                if (primed && ({i_rsp, i_flags, i_branch, i_branch_pc} !==
                               {exp_rsp, exp_flags, exp_branch, exp_pc}))
                begin
                        $display("ERROR %0t: rsp %h flags %b br %b pc %h, expected %h %b %b %h",
                                 $time, i_rsp, i_flags, i_branch, i_branch_pc,
                                 exp_rsp, exp_flags, exp_branch, exp_pc);
                        o_errors++;
                end

                if (i_reset)
                begin
                        exp_rsp   = '0;
                        exp_flags = '0;
                        asleep    = 1'b0;
                        primed    = 1'b1;
                end
                else if (i_clear)
                begin
                        exp_rsp = '0;
                        asleep  = 1'b0;
                end
                else if (!i_stall)
                begin
                        exp_rsp = '0;               // Bubble while asleep.
                        if (!asleep)
                        begin
                                exp_rsp = {valid, i_req.exc, outcome[`ALU_DATA_W-1:0], i_req.dest};
                                if (valid)
                                begin
                                        exp_flags = outcome[`ALU_DATA_W+3:`ALU_DATA_W];
                                end
                                asleep = i_req.exc ||
                                         (valid && i_req.dest == reg_idx_t'(`ALU_PC_INDEX));
                        end
                end
        end

endmodule

// File: verif/tb_alu_stage.sv
`timescale 1ns/10ps

`include "alu_defines.svh"

module tb_alu_stage
        import alu_pkg::*;
();

        logic      clk;
        logic      reset;
        logic      clear;
        logic      stall;
        exec_req_t req;
        exec_rsp_t rsp;
        flags_t    flags;
        logic      branch;
        word_t     branch_pc;
        int        checker_errors;
        int        seed;
        int        hangs;
        int        tests_passed;
        int        tests_failed;

        alu_stage u_dut (
                .i_clk       (clk),
                .i_reset     (reset),
                .i_clear     (clear),
                .i_stall     (stall),
                .i_req       (req),
                .o_rsp       (rsp),
                .o_flags     (flags),
                .o_branch    (branch),
                .o_branch_pc (branch_pc)
        );

        alu_stage_checker u_check (
                .i_clk       (clk),
                .i_reset     (reset),
                .i_clear     (clear),
                .i_stall     (stall),
                .i_req       (req),
                .i_rsp       (rsp),
                .i_flags     (flags),
                .i_branch    (branch),
                .i_branch_pc (branch_pc),
                .o_errors    (checker_errors)
        );

        initial
        begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        // A quarter of the operands are carry and overflow corner values.
        function automatic word_t random_word();
                logic [31:0] r;

                r = $random(seed);
                case (r[3:0])
                        4'd0:    return '0;
                        4'd1:    return '1;
                        4'd2:    return 32'h8000_0000;
                        4'd3:    return 32'h7fff_ffff;
                        default: return $random(seed);
                endcase
        endfunction

        function automatic exec_req_t random_req(input logic arith, input cond_e cond,
                                                 input logic allow_pc);
                exec_req_t   r;
                logic [31:0] rnd;
                logic [3:0]  k;

                rnd           = $random(seed);
                r.rn          = random_word();
                r.rm          = random_word();
                r.shift_carry = rnd[0];
                r.rrx         = rnd[1];
                r.flag_update = rnd[2] | rnd[3];
                r.exc         = 1'b0;
                r.cond        = cond;
                k             = 4'(rnd[15:8] % 8'd6);
                r.op          = alu_op_e'(arith ? k + 4'd6 : k);
                r.dest        = reg_idx_t'(rnd[23:16] % 8'd46);
                if (allow_pc && rnd[26:24] == 3'd0)
                begin
                        r.dest = reg_idx_t'(`ALU_PC_INDEX);
                end
                else if (r.dest == reg_idx_t'(`ALU_PC_INDEX))
                begin
                        r.dest = reg_idx_t'(`ALU_PC_INDEX + 1);
                end
                return r;
        endfunction

        function automatic exec_req_t idle_req();
                exec_req_t r;

                r      = '0;
                r.cond = NV;    // Empty slot.
                return r;
        endfunction

        function automatic int total_errors();
                return checker_errors + hangs + u_dut.u_reg.u_assert.failures;
        endfunction

        task automatic issue(input exec_req_t r, input logic clr);
                @(negedge clk);
                req   = r;
                clear = clr;
                stall = 1'b0;
        endtask

        // Upstream presents the request and keeps it steady until the stall lifts.
        task automatic hold_stall(input exec_req_t r, input int len);
                repeat (len)
                begin
                        @(negedge clk);
                        req   = r;
                        stall = 1'b1;
                end
                issue(r, 1'b0);
        endtask

        task automatic wait_rsp(input logic want_exc, input int limit);
                int   n;
                logic seen;

                n    = 0;
                seen = 1'b0;
                while (!seen && n < limit)
                begin
                        @(negedge clk);
                        seen = want_exc ? rsp.exc : rsp.valid;
                        n++;
                end
                if (!seen)
                begin
                        $display("Timeout: no %s slot came out within %0d cycles",
                                 want_exc ? "exception" : "valid", limit);
                        hangs++;
                end
        endtask

        task automatic end_test(input string name, input int mark);
                int errs;

                issue(idle_req(), 1'b0);
                issue(idle_req(), 1'b0);
                @(negedge clk);
                errs = total_errors() - mark;
                if (errs == 0)
                begin
                        tests_passed++;
                        $display("Test %s: passed", name);
                end
                else
                begin
                        tests_failed++;
                        $display("Test %s: failed with %0d errors", name, errs);
                end
        endtask

        initial
        begin
                int          mark;
                int          i;
                logic [31:0] rnd;
                exec_req_t   br;

                seed  = 32'h3ea1_68ab;
                reset = 1'b1;
                clear = 1'b0;
                stall = 1'b0;
                req   = idle_req();
                repeat (16) @(posedge clk);
                @(negedge clk);
                reset = 1'b0;

                mark = total_errors();
                for (i = 0; i < 200; i++)
                begin
                        issue(random_req(1'b0, AL, 1'b0), 1'b0);
                end
                end_test("logical operations", mark);

                mark = total_errors();
                for (i = 0; i < 200; i++)
                begin
                        issue(random_req(1'b1, AL, 1'b0), 1'b0);
                end
                end_test("arithmetic operations", mark);

                // Each code meets eight random flag states.
                mark = total_errors();
                for (i = 0; i < 128; i++)
                begin
                        issue(random_req(1'b1, AL, 1'b0), 1'b0);
                        issue(random_req(i[0], cond_e'(i[6:3]), 1'b0), 1'b0);
                end
                end_test("condition codes", mark);

                mark = total_errors();
                for (i = 0; i < 4; i++)
                begin
                        br      = random_req(i[0], AL, 1'b0);
                        br.dest = reg_idx_t'(`ALU_PC_INDEX);
                        hold_stall(br, 2);
                        issue(br, 1'b0);        // Asleep now, no second redirect.
                        repeat (5) issue(random_req(1'b1, AL, 1'b0), 1'b0);
                        issue(idle_req(), 1'b1);
                        issue(random_req(1'b0, AL, 1'b0), 1'b0);
                        wait_rsp(1'b0, 8);
                end
                end_test("branch and sleep", mark);

                mark = total_errors();
                for (i = 0; i < 4; i++)
                begin
                        rnd    = $random(seed);
                        br     = random_req(1'b1, i[0] ? AL : cond_e'(rnd[3:0]), 1'b0);
                        br.exc = 1'b1;
                        if (i[0])
                        begin
                                br.dest = reg_idx_t'(`ALU_PC_INDEX);    // Tagged PC write.
                        end
                        issue(br, 1'b0);
                        wait_rsp(1'b1, 4);
                        repeat (3) issue(random_req(1'b0, AL, 1'b0), 1'b0);
                        issue(idle_req(), 1'b1);
                        issue(random_req(1'b1, AL, 1'b0), 1'b0);
                        wait_rsp(1'b0, 8);
                end
                end_test("exception tag", mark);

                mark = total_errors();
                for (i = 0; i < 150; i++)
                begin
                        rnd = $random(seed);
                        issue(random_req(rnd[4], rnd[13] ? AL : cond_e'(rnd[17:14]), 1'b1), 1'b0);
                        if (rnd[7:5] == 3'd0)
                        begin
                                hold_stall(random_req(rnd[4], AL, 1'b1), int'(rnd[9:8]) + 1);
                        end
                        else if (rnd[12:10] == 3'd0)
                        begin
                                br      = random_req(1'b1, AL, 1'b0);
                                br.dest = reg_idx_t'(`ALU_PC_INDEX);
                                issue(br, 1'b1);
                        end
                end
                end_test("stall and clear", mark);

                $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
                if (tests_failed == 0 && total_errors() == 0)
                begin
                        $display("Result: PASSED");
                end
                else
                begin
                        $display("Result: FAILED");
                end
                $finish;
        end

endmodule

// File: alu_stage.f
+incdir+include
hw/alu_pkg.sv
hw/cond_check.sv
hw/alu_datapath.sv
hw/alu_stage_reg.sv
hw/alu_stage.sv
verif/alu_stage_assert.sv
verif/alu_stage_checker.sv
verif/tb_alu_stage.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
        && verilator --binary --timing --assert --top-module tb_alu_stage -f alu_stage.f \
        && ./obj_dir/Vtb_alu_stage | tee /dev/stderr | grep "Result: PASSED" > /dev/null \
        && echo "Simulation passed." \
        || { echo "Simulation failed."; exit 1; }
